/* Makefile */
# Verilator build and run for the decode and conditional-execution controller

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := cpu_control_tb
FILELIST  := cpu_control.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

# The simulator exits non-zero on $$fatal, so make fails with it
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* cpu_control.f */
+incdir+verification
src/ctrl_isa_pkg.sv
src/ctrl_dev_pkg.sv
src/instr_fields.sv
src/cond_eval.sv
src/dev_select.sv
src/cpu_control.sv
verification/cpu_control_tb.sv

/* src/cond_eval.sv */
// --------------------------------------------------------------------------
// Condition evaluation. Latches condition bits and flags on load, picks one
// flag of 16 and drives exec_n low when the instruction should take effect
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module cond_eval (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 load,
    input  logic [ctrl_isa_pkg::instr_width-1:0] instruction,
    input  logic [7:0]                           flags_n,    // c z o n gt lt eq ne
    input  logic                                 flag_di_n,
    input  logic                                 flag_do_n,

    output logic                                 exec_n
);

    ctrl_isa_pkg::instr_word_t            word_in;   // Field view of the input
    logic [ctrl_isa_pkg::cond_width-1:0]  cond_q;
    logic                                 invert_q;
    logic [7:0]                           flags_q_n; // ALU flags, low = set
    logic                                 di_q_n;
    logic                                 do_q_n;
    logic                                 flag_sel_n; // Chosen flag, low = set
    logic                                 cond_met;

    assign word_in = instruction;

    // ----------------------------------------------------------------------
    // Condition and flag register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cond_q    <= ctrl_isa_pkg::cond_always;
            invert_q  <= 1'b0;
            flags_q_n <= '1;                 // All flags clear
            di_q_n    <= 1'b1;
            do_q_n    <= 1'b1;
        end else if (load) begin
            cond_q    <= {word_in.field.cond_top, word_in.field.cond_bot};
            invert_q  <= word_in.field.cond_invert;
            flags_q_n <= flags_n;
            di_q_n    <= flag_di_n;
            do_q_n    <= flag_do_n;
        end
    end

    // ----------------------------------------------------------------------
    // 16-way flag select
    // ----------------------------------------------------------------------
    always_comb begin
        case (cond_q)
            ctrl_isa_pkg::cond_always:   flag_sel_n = 1'b0;           // Always set
            ctrl_isa_pkg::cond_carry:    flag_sel_n = flags_q_n[7];
            ctrl_isa_pkg::cond_zero:     flag_sel_n = flags_q_n[6];
            ctrl_isa_pkg::cond_overflow: flag_sel_n = flags_q_n[5];
            ctrl_isa_pkg::cond_negative: flag_sel_n = flags_q_n[4];
            ctrl_isa_pkg::cond_gt:       flag_sel_n = flags_q_n[3];
            ctrl_isa_pkg::cond_lt:       flag_sel_n = flags_q_n[2];
            ctrl_isa_pkg::cond_eq:       flag_sel_n = flags_q_n[1];
            ctrl_isa_pkg::cond_ne:       flag_sel_n = flags_q_n[0];
            ctrl_isa_pkg::cond_di:       flag_sel_n = di_q_n;
            ctrl_isa_pkg::cond_do:       flag_sel_n = do_q_n;
            default:                     flag_sel_n = 1'b0;           // Reserved codes
        endcase
    end

    // Met when the chosen flag is set, invert flips the decision
    assign cond_met = ~flag_sel_n;
    assign exec_n   = ~(cond_met ^ invert_q);

    // Target and flag gating downstream depend on a clean decision
    a_exec_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        !$isunknown(exec_n)
    ) else $error("exec_n unknown");

endmodule

/* src/cpu_control.sv */
// --------------------------------------------------------------------------
// Decode and conditional-execution controller, top level
// Load latches instruction and flags, outputs follow one cycle later
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module cpu_control (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  load,
    input  logic [ctrl_isa_pkg::instr_width-1:0]  instruction,
    input  logic [7:0]                            flags_n,      // c z o n gt lt eq ne
    input  logic                                  flag_di_n,    // UART rx ready
    input  logic                                  flag_do_n,    // UART tx ready

    output logic [ctrl_isa_pkg::alu_op_width-1:0] alu_op,
    output logic [ctrl_dev_pkg::adev_count-1:0]   adev_sel_n,
    output logic [ctrl_dev_pkg::bdev_count-1:0]   bdev_sel_n,
    output logic [ctrl_dev_pkg::tdev_count-1:0]   tdev_sel_n,
    output logic                                  set_flags_n,
    output logic [7:0]                            immed8,
    output logic                                  immed_en_n,
    output logic [15:0]                           direct_address,
    output logic                                  direct_en_n,
    output logic                                  addrmode_register_n
);

    // ----------------------------------------------------------------------
    // Internal wiring
    // ----------------------------------------------------------------------
    logic                                          valid;
    logic                                          exec_n;
    logic [$clog2(ctrl_dev_pkg::adev_count)-1:0]   abus_dev;
    logic [ctrl_dev_pkg::dev_code_width-1:0]       bbus_dev;
    logic [ctrl_dev_pkg::dev_code_width-1:0]       targ_dev;
    logic                                          set_flags_req_n;

    // Field decode, owns the instruction register
    instr_fields fields0 (
        .clk                 (clk),
        .arst_n              (arst_n),
        .load                (load),
        .instruction         (instruction),
        .valid               (valid),
        .alu_op              (alu_op),
        .abus_dev            (abus_dev),
        .bbus_dev            (bbus_dev),
        .targ_dev            (targ_dev),
        .set_flags_req_n     (set_flags_req_n),
        .immed8              (immed8),
        .direct_address      (direct_address),
        .direct_en_n         (direct_en_n),
        .addrmode_register_n (addrmode_register_n)
    );

    // Condition path, same word on the same edge
    cond_eval cond0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .load        (load),
        .instruction (instruction),
        .flags_n     (flags_n),
        .flag_di_n   (flag_di_n),
        .flag_do_n   (flag_do_n),
        .exec_n      (exec_n)
    );

    // Select lines and set-flags strobe
    dev_select sel0 (
        .valid           (valid),
        .exec_n          (exec_n),
        .abus_dev        (abus_dev),
        .bbus_dev        (bbus_dev),
        .targ_dev        (targ_dev),
        .set_flags_req_n (set_flags_req_n),
        .adev_sel_n      (adev_sel_n),
        .bdev_sel_n      (bdev_sel_n),
        .tdev_sel_n      (tdev_sel_n),
        .set_flags_n     (set_flags_n),
        .immed_en_n      (immed_en_n)
    );

endmodule

/* src/ctrl_dev_pkg.sv */
// --------------------------------------------------------------------------
// Device select counts and indices for the A, B and target buses
// --------------------------------------------------------------------------
package ctrl_dev_pkg;

    // ----------------------------------------------------------------------
    // Bus sizes
    // ----------------------------------------------------------------------
    localparam int adev_count     = 8;   // A bus, one 3-to-8 decode
    localparam int bdev_count     = 16;  // B bus, two decodes stacked
    localparam int tdev_count     = 16;  // Target devices, same shape as B
    localparam int dev_code_width = 4;   // B and target code width

    // ----------------------------------------------------------------------
    // Named devices
    // ----------------------------------------------------------------------

    // B source driven from the immediate byte of the instruction
    localparam int bdev_immed = 4;

endpackage

/* src/ctrl_isa_pkg.sv */
// --------------------------------------------------------------------------
// Instruction word layout and condition codes of the microcoded controller
// Lane view matches the six ROM byte lanes, field view is the decode
// --------------------------------------------------------------------------
package ctrl_isa_pkg;

    localparam int instr_width  = 48;   // Six ROM lanes of 8 bits
    localparam int cond_width   = 4;    // 16-way condition select
    localparam int alu_op_width = 5;

    // ----------------------------------------------------------------------
    // Condition codes, flag selected by each
    // ----------------------------------------------------------------------
    localparam logic [cond_width-1:0] cond_always   = 4'd0;
    localparam logic [cond_width-1:0] cond_carry    = 4'd1;
    localparam logic [cond_width-1:0] cond_zero     = 4'd2;
    localparam logic [cond_width-1:0] cond_overflow = 4'd3;
    localparam logic [cond_width-1:0] cond_negative = 4'd4;
    localparam logic [cond_width-1:0] cond_gt       = 4'd5;
    localparam logic [cond_width-1:0] cond_lt       = 4'd6;
    localparam logic [cond_width-1:0] cond_eq       = 4'd7;
    localparam logic [cond_width-1:0] cond_ne       = 4'd8;
    localparam logic [cond_width-1:0] cond_di       = 4'd9;   // UART data in ready
    localparam logic [cond_width-1:0] cond_do       = 4'd10;  // UART data out ready
    // 11 to 15 reserved, treated as always

    // ----------------------------------------------------------------------
    // One 48-bit word, two decodes
    // ----------------------------------------------------------------------
    typedef union packed {
        logic [6:1][7:0] lane;          // Lane 1 lowest, lane 6 highest
        struct packed {
            // Lane 6
            logic [alu_op_width-1:0] alu_op;
            // Lanes 6 and 5, split at the lane boundary
            logic [3:0] targ_dev;
            // Lane 5
            logic [2:0] abus_dev;
            logic [2:0] bbus_dev_lo;
            logic       cond_top;       // Picks high half of the 16 flags
            // Lane 4
            logic [2:0] cond_bot;
            logic       set_flags_n;    // Low requests a flag update
            logic       cond_invert;    // High inverts the condition
            logic       unused;         // Spare bit
            logic       bbus_dev_hi;
            logic       amode;          // 0 register, 1 direct
            // Lanes 3 to 1
            logic [7:0] direct_hi;
            logic [7:0] direct_lo;
            logic [7:0] immed8;
        } field;
    } instr_word_t;

endpackage

/* src/dev_select.sv */
// --------------------------------------------------------------------------
// Device select decode. Turns the A, B and target codes into active-low
// one-of-N lines, target and set-flags gated by the execute decision
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module dev_select (
    input  logic                                        valid,
    input  logic                                        exec_n,    // Low = execute
    input  logic [$clog2(ctrl_dev_pkg::adev_count)-1:0] abus_dev,
    input  logic [ctrl_dev_pkg::dev_code_width-1:0]     bbus_dev,
    input  logic [ctrl_dev_pkg::dev_code_width-1:0]     targ_dev,
    input  logic                                        set_flags_req_n,

    output logic [ctrl_dev_pkg::adev_count-1:0]         adev_sel_n,
    output logic [ctrl_dev_pkg::bdev_count-1:0]         bdev_sel_n,
    output logic [ctrl_dev_pkg::tdev_count-1:0]         tdev_sel_n,
    output logic                                        set_flags_n,
    output logic                                        immed_en_n
);

    // ----------------------------------------------------------------------
    // Shared decoder with one low line when enabled
    // ----------------------------------------------------------------------
    function automatic logic [ctrl_dev_pkg::bdev_count-1:0] decode_n(
        input logic                                    en,
        input logic [ctrl_dev_pkg::dev_code_width-1:0] code
    );
        logic [ctrl_dev_pkg::bdev_count-1:0] lines;
        lines = '1;                       // Idle high
        if (en)
            lines[code] = 1'b0;
        return lines;
    endfunction

    logic [ctrl_dev_pkg::bdev_count-1:0] a_lines_n; // Upper half never selected
    logic                                do_target;  // Execute on a loaded word

    // ----------------------------------------------------------------------
    // Select lines
    // ----------------------------------------------------------------------
    always_comb begin
        do_target = valid & ~exec_n;

        // A bus uses the low eight lines only
        a_lines_n  = decode_n(valid, {1'b0, abus_dev});
        adev_sel_n = a_lines_n[ctrl_dev_pkg::adev_count-1:0];

        bdev_sel_n = decode_n(valid, bbus_dev);       // Sources are not gated
        tdev_sel_n = decode_n(do_target, targ_dev);   // Write suppressed on fail

        // Flag update needs both the request and a passing condition
        set_flags_n = ~(do_target & ~set_flags_req_n);

        // Immediate byte drives the B bus while its device is selected
        immed_en_n = bdev_sel_n[ctrl_dev_pkg::bdev_immed];

        // ------------------------------------------------------------------
        // Checks on the decoded buses
        // ------------------------------------------------------------------
        assert ($onehot0(~adev_sel_n))
            else $error("more than one A source selected");
        assert ($onehot0(~bdev_sel_n))
            else $error("more than one B source selected");
        assert ($onehot0(~tdev_sel_n))
            else $error("more than one target selected");
        assert (!(exec_n && tdev_sel_n != '1))
            else $error("target selected with condition failed");
    end

endmodule

/* src/instr_fields.sv */
// --------------------------------------------------------------------------
// Instruction register and field decode
// Captures the word on load, drives device codes and the address-mode pair
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module instr_fields (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  load,
    input  logic [ctrl_isa_pkg::instr_width-1:0]  instruction,

    output logic                                  valid,
    output logic [ctrl_isa_pkg::alu_op_width-1:0] alu_op,
    output logic [$clog2(ctrl_dev_pkg::adev_count)-1:0] abus_dev,
    output logic [ctrl_dev_pkg::dev_code_width-1:0] bbus_dev,
    output logic [ctrl_dev_pkg::dev_code_width-1:0] targ_dev,
    output logic                                  set_flags_req_n,
    output logic [7:0]                            immed8,
    output logic [15:0]                           direct_address,
    output logic                                  direct_en_n,
    output logic                                  addrmode_register_n
);

    // ----------------------------------------------------------------------
    // Instruction register
    // ----------------------------------------------------------------------
    ctrl_isa_pkg::instr_word_t ir;   // Latched word

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ir    <= '0;                   // alu_op reads 0 out of reset
            valid <= 1'b0;
        end else if (load) begin
            ir    <= instruction;
            valid <= 1'b1;                 // Sticks after first load
        end
    end

    // ----------------------------------------------------------------------
    // Field decode
    // ----------------------------------------------------------------------
    assign alu_op   = ir.field.alu_op;
    assign abus_dev = ir.field.abus_dev;
    assign targ_dev = ir.field.targ_dev;    // Spans lanes 6 and 5

    // B code split across lanes 5 and 4
    assign bbus_dev = {ir.field.bbus_dev_hi, ir.field.bbus_dev_lo};

    assign set_flags_req_n = ir.field.set_flags_n;  // Gated later by exec

    // Immediate byte, enable comes from the B decode
    assign immed8 = ir.field.immed8;

    // Direct address is lanes 3 and 2 taken whole
    assign direct_address = {ir.lane[3], ir.lane[2]};

    // ----------------------------------------------------------------------
    // Address mode
    // ----------------------------------------------------------------------

    // amode low selects register addressing, high drives the direct address
    // Both stay inactive until a word has been loaded
    always_comb begin
        addrmode_register_n = ~(valid & ~ir.field.amode);
        direct_en_n         = ~(valid &  ir.field.amode);
    end

    // Only one source may own the address bus
    a_amode_excl: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(!direct_en_n && !addrmode_register_n)
    ) else $error("direct and register address modes both enabled");

endmodule

/* verification/cpu_control_vectors.svh */
// --------------------------------------------------------------------------
// Row type and directed rows of the controller testbench
// Included inside the testbench module, rows go into one queue
// --------------------------------------------------------------------------
`ifndef CPU_CONTROL_VECTORS_SVH
`define CPU_CONTROL_VECTORS_SVH

typedef struct {
    string       name;
    logic [4:0]  alu_op;
    logic [2:0]  abus;
    logic [3:0]  bbus;
    logic [3:0]  targ;
    logic [3:0]  cond;
    logic        inv;        // Condition invert bit
    logic        sf_n;       // Low requests a flag update
    logic        amode;      // 0 register, 1 direct
    logic [15:0] direct;
    logic [7:0]  immed;
    logic [7:0]  flags_n;    // c z o n gt lt eq ne, low = set
    logic        di_n;
    logic        do_n;
    logic        exp_exec;   // Expected: target write and flag update go ahead
} vec_t;

vec_t rows[$];  // Applied in order by the main loop

function automatic vec_t make_row(
    input string       nm,
    input logic [4:0]  alu_op,
    input logic [2:0]  abus,
    input logic [3:0]  bbus, targ, cond,
    input logic        inv, sf_n, amode,
    input logic [15:0] direct,
    input logic [7:0]  immed, flags_n,
    input logic        di_n, do_n, exp_exec
);
    vec_t r;
    r = '{nm, alu_op, abus, bbus, targ, cond, inv, sf_n, amode, direct, immed,
          flags_n, di_n, do_n, exp_exec};
    return r;
endfunction

// Columns: name, alu, A, B, target, cond, inv, sf_n, amode, direct, immed,
// flags_n, di_n, do_n, expected execute
task automatic fill_directed();
    rows.push_back(make_row("alu_a0_b0", 5'h01, 3'd0, 4'd0, 4'd3, 4'd0, 1'b0, 1'b0,
                            1'b0, 16'h1234, 8'h00, 8'hff, 1'b1, 1'b1, 1'b1));
    rows.push_back(make_row("immed_b4", 5'h0a, 3'd2, 4'd4, 4'd1, 4'd0, 1'b0, 1'b1,
                            1'b0, 16'h0000, 8'ha5, 8'hff, 1'b1, 1'b1, 1'b1));
    rows.push_back(make_row("b_high_bit", 5'h1f, 3'd7, 4'd12, 4'd15, 4'd0, 1'b0, 1'b1,
                            1'b0, 16'h0000, 8'h3c, 8'hff, 1'b1, 1'b1, 1'b1));
    rows.push_back(make_row("direct_mode", 5'h05, 3'd4, 4'd9, 4'd8, 4'd0, 1'b0, 1'b1,
                            1'b1, 16'hbeef, 8'h11, 8'hff, 1'b1, 1'b1, 1'b1));
    rows.push_back(make_row("carry_taken", 5'h03, 3'd1, 4'd2, 4'd5, 4'd1, 1'b0, 1'b0,
                            1'b0, 16'h00ff, 8'h00, 8'h7f, 1'b1, 1'b1, 1'b1));
    rows.push_back(make_row("carry_skipped", 5'h03, 3'd1, 4'd2, 4'd5, 4'd1, 1'b0, 1'b0,
                            1'b0, 16'h00ff, 8'h00, 8'hff, 1'b1, 1'b1, 1'b0));
    rows.push_back(make_row("never", 5'h00, 3'd3, 4'd6, 4'd2, 4'd0, 1'b1, 1'b0,
                            1'b1, 16'h8001, 8'h7e, 8'h00, 1'b0, 1'b0, 1'b0));
    rows.push_back(make_row("uart_di", 5'h12, 3'd5, 4'd4, 4'd10, 4'd9, 1'b0, 1'b0,
                            1'b0, 16'h4242, 8'h55, 8'hff, 1'b0, 1'b1, 1'b1));
    rows.push_back(make_row("uart_do_inv", 5'h12, 3'd6, 4'd1, 4'd11, 4'd10, 1'b1, 1'b0,
                            1'b1, 16'hc0de, 8'haa, 8'hff, 1'b1, 1'b0, 1'b0));
endtask

`endif

/* verification/cpu_control_tb.sv */
// --------------------------------------------------------------------------
// Testbench for the controller. Applies a table of rows with one load each,
// checks outputs after the capture edge and again after a cycle without load
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module cpu_control_tb;

    localparam int update_limit = 4;    // Cycles allowed for outputs to follow
    localparam int random_count = 32;

    logic        clk;
    logic        arst_n;
    logic        load;
    logic [47:0] instruction;
    logic [7:0]  flags_n;
    logic        flag_di_n;
    logic        flag_do_n;
    logic [4:0]  alu_op;
    logic [7:0]  adev_sel_n;
    logic [15:0] bdev_sel_n;
    logic [15:0] tdev_sel_n;
    logic        set_flags_n;
    logic [7:0]  immed8;
    logic        immed_en_n;
    logic [15:0] direct_address;
    logic        direct_en_n;
    logic        addrmode_register_n;

    logic [31:0] lcg_state;             // Random state
    string       cur_name;              // Row under test

    `include "cpu_control_vectors.svh"

    cpu_control dut0 (
        .clk                 (clk),
        .arst_n              (arst_n),
        .load                (load),
        .instruction         (instruction),
        .flags_n             (flags_n),
        .flag_di_n           (flag_di_n),
        .flag_do_n           (flag_do_n),
        .alu_op              (alu_op),
        .adev_sel_n          (adev_sel_n),
        .bdev_sel_n          (bdev_sel_n),
        .tdev_sel_n          (tdev_sel_n),
        .set_flags_n         (set_flags_n),
        .immed8              (immed8),
        .immed_en_n          (immed_en_n),
        .direct_address      (direct_address),
        .direct_en_n         (direct_en_n),
        .addrmode_register_n (addrmode_register_n)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;         // 100 ns period
    end

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [47:0] rand48();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi[31:16], lo};
    endfunction

    // Packs the row in field order from alu_op down to the immediate byte
    function automatic logic [47:0] pack_instr(input vec_t r);
        return {r.alu_op, r.targ, r.abus, r.bbus[2:0], r.cond, r.sf_n, r.inv,
                1'b0, r.bbus[3], r.amode, r.direct, r.immed};
    endfunction

    // Met bit per condition code with 0 and 11..15 always met
    function automatic logic cond_passes(input vec_t r);
        logic [15:0] met;
        met = {5'h1f, ~r.do_n, ~r.di_n,
               ~r.flags_n[0], ~r.flags_n[1], ~r.flags_n[2], ~r.flags_n[3],
               ~r.flags_n[4], ~r.flags_n[5], ~r.flags_n[6], ~r.flags_n[7], 1'b1};
        return met[r.cond] ^ r.inv;
    endfunction

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected)
            else stop_with_failure($sformatf("Error %s %s: expected 0x%0h actual 0x%0h",
                                             cur_name, what, expected, actual));
    endtask

    task automatic check_outputs(input vec_t r);
        logic [7:0]  exp_a;
        logic [15:0] exp_b;
        logic [15:0] exp_t;
        logic        exp_ie;
        logic        exp_sf;
        logic        exp_den;
        exp_a   = ~(8'h01 << r.abus);
        exp_b   = ~(16'h0001 << r.bbus);
        exp_t   = r.exp_exec ? ~(16'h0001 << r.targ) : 16'hffff;    // Write suppressed
        exp_ie  = (r.bbus == 4'(ctrl_dev_pkg::bdev_immed)) ? 1'b0 : 1'b1;
        exp_sf  = (r.exp_exec && !r.sf_n) ? 1'b0 : 1'b1;    // Requested and executed
        exp_den = r.amode ? 1'b0 : 1'b1;                     // Direct mode drives
        compare_value("alu_op", 32'(r.alu_op), 32'(alu_op));
        compare_value("adev_sel_n", 32'(exp_a), 32'(adev_sel_n));
        compare_value("bdev_sel_n", 32'(exp_b), 32'(bdev_sel_n));
        compare_value("tdev_sel_n", 32'(exp_t), 32'(tdev_sel_n));
        compare_value("set_flags_n", 32'(exp_sf), 32'(set_flags_n));
        compare_value("immed8", 32'(r.immed), 32'(immed8));
        compare_value("immed_en_n", 32'(exp_ie), 32'(immed_en_n));
        compare_value("addrmode_register_n", 32'(r.amode), 32'(addrmode_register_n));
        compare_value("direct_en_n", 32'(exp_den), 32'(direct_en_n));
        compare_value("direct_address", 32'(r.direct), 32'(direct_address));
    endtask

    task automatic confirm_reset_state();
        cur_name = "reset";
        compare_value("alu_op", 32'd0, 32'(alu_op));
        compare_value("adev_sel_n", 32'h0000_00ff, 32'(adev_sel_n));
        compare_value("bdev_sel_n", 32'h0000_ffff, 32'(bdev_sel_n));
        compare_value("tdev_sel_n", 32'h0000_ffff, 32'(tdev_sel_n));
        compare_value("set_flags_n", 32'd1, 32'(set_flags_n));
        compare_value("immed_en_n", 32'd1, 32'(immed_en_n));
        compare_value("direct_en_n", 32'd1, 32'(direct_en_n));
        compare_value("addrmode_register_n", 32'd1, 32'(addrmode_register_n));
    endtask

    // ----------------------------------------------------------------------
    // Generated rows
    // ----------------------------------------------------------------------

    // Chosen flag set or clear with every other flag at the opposite level
    task automatic sweep_conditions();
        vec_t        r;
        logic [31:0] rnd;
        logic [31:0] rnd2;
        logic [15:0] lvl;
        logic [3:0]  code;
        logic        met;
        for (int c = 0; c < 16; c++) begin
            for (int s = 0; s < 2; s++) begin
                for (int v = 0; v < 2; v++) begin
                    code = 4'(c);
                    rnd  = next_rand();
                    rnd2 = next_rand();
                    lvl  = (s == 1) ? 16'hffff : 16'h0000;
                    lvl[code] = (s == 1) ? 1'b0 : 1'b1;     // Low = set
                    met  = (c >= 1 && c <= 10) ? (s == 1) : 1'b1;
                    r = make_row($sformatf("cond%0d_%s_inv%0d", c, (s == 1) ? "set" : "clr", v),
                                 rnd[31:27], rnd[26:24], rnd[23:20], rnd[19:16], code,
                                 1'(v), rnd[15], rnd[14], rnd2[31:16], rnd2[15:8],
                                 {lvl[1], lvl[2], lvl[3], lvl[4], lvl[5], lvl[6], lvl[7], lvl[8]},
                                 lvl[9], lvl[10], met ^ 1'(v));
                    rows.push_back(r);
                end
            end
        end
    endtask

    task automatic draw_random_rows(input int n);
        vec_t        r;
        logic [31:0] rnd;
        logic [31:0] rnd2;
        logic [31:0] rnd3;
        for (int i = 0; i < n; i++) begin
            rnd  = next_rand();
            rnd2 = next_rand();
            rnd3 = next_rand();
            r = make_row($sformatf("rand%0d", i), rnd[31:27], rnd[26:24], rnd[23:20],
                         rnd[19:16], rnd[15:12], rnd[11], rnd[10], rnd[9], rnd2[31:16],
                         rnd2[15:8], rnd3[31:24], rnd3[23], rnd3[22], 1'b0);
            r.exp_exec = cond_passes(r);
            rows.push_back(r);
        end
    endtask

    // ----------------------------------------------------------------------
    // One row with a load, a wait, a check and a hold check
    // ----------------------------------------------------------------------
    task automatic apply_row(input vec_t r);
        int          waited;
        logic [7:0]  exp_a;
        logic [31:0] rnd;
        cur_name    = r.name;
        exp_a       = ~(8'h01 << r.abus);
        load        = 1'b1;
        instruction = pack_instr(r);
        flags_n     = r.flags_n;
        flag_di_n   = r.di_n;
        flag_do_n   = r.do_n;
        waited      = 0;
        do begin
            @(posedge clk);
            #5;
            load = 1'b0;
            waited++;
        end while (adev_sel_n !== exp_a && waited < update_limit);
        if (adev_sel_n !== exp_a)
            stop_with_failure({"Outputs did not follow the load in time, row ", r.name});
        compare_value("latency", 32'd1, 32'(waited));
        check_outputs(r);
        // New inputs without load must not reach the outputs
        rnd         = next_rand();
        instruction = rand48();
        flags_n     = rnd[31:24];
        flag_di_n   = rnd[23];
        flag_do_n   = rnd[22];
        @(posedge clk);
        #5;
        cur_name = {r.name, " hold"};
        check_outputs(r);
    endtask

    initial begin
        #500_000;
        stop_with_failure("Watchdog expired before the run finished");
    end

    initial begin
        lcg_state   = 32'd93031;
        arst_n      = 1'b0;
        load        = 1'b0;
        instruction = '0;
        flags_n     = 8'hff;            // All flags clear
        flag_di_n   = 1'b1;
        flag_do_n   = 1'b1;
        repeat (2) @(posedge clk);
        #5;
        arst_n = 1'b1;
        confirm_reset_state();
        fill_directed();
        sweep_conditions();
        draw_random_rows(random_count);
        foreach (rows[i])
            apply_row(rows[i]);
        $display("=== PASS ===");
        $finish;
    end

endmodule
